//--- design/lc_pkg.sv
// Shared definitions for the page scan part of the link controller.
// Holds the substate encoding and the register widths used by the RTL
// and the testbench. Refer to the members by scoped name.

`default_nettype none

package lc_pkg;

  // page scan substates
  typedef enum logic [1:0] {
    ST_STANDBY    = 2'd0,
    ST_PAGE_SCAN  = 2'd1,
    ST_SLAVE_RESP = 2'd2,
    ST_CONNECTION = 2'd3
  } ps_state_t;

  // width of the scan interval and scan window registers that count slots
  localparam int unsigned TSCAN_W = 16;

  // width of the slave response slot counter
  localparam int unsigned RESP_CNT_W = 4;

  // slots a slave page response may stall before it is abandoned
  localparam logic [RESP_CNT_W-1:0] RESP_TO_SLOTS = RESP_CNT_W'(8);

endpackage

`default_nettype wire

//--- design/ps_state_if.sv
// Substate flags and ID response strobes passed from the substate
// sequencer to the page scan controller. The sequencer drives src and
// the controller reads dst.

`timescale 1ns/1ns
`default_nettype none

interface ps_state_if;

  logic ps;        // page scan substate active
  logic spr;       // slave page response substate active
  logic pstxid;    // ID response waiting to go out
  logic corr_endp; // one clock at the end of the half slot delay

  modport src (
    output ps,
    output spr,
    output pstxid,
    output corr_endp
  );

  modport dst (
    input ps,
    input spr,
    input pstxid,
    input corr_endp
  );

endinterface

`default_nettype wire

//--- design/slot_timer.sv
// Base timing for the link controller. Divides clk_6M down to a 1 us
// pulse and then to a slot pulse every SLOT_US microseconds. Both
// outputs are single clock strobes.

`timescale 1ns/1ns
`default_nettype none

module slot_timer #(
  parameter int unsigned CLK_PER_US = 6,
  parameter int unsigned SLOT_US    = 625
) (
  input  wire  clk_6M,
  input  wire  rstz,
  output logic p_1us,
  output logic tslot_p
);

  localparam int unsigned CLK_W = $clog2(CLK_PER_US + 1);
  localparam int unsigned US_W  = $clog2(SLOT_US + 1);

  localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(CLK_PER_US - 1);
  localparam logic [US_W-1:0]  US_LAST  = US_W'(SLOT_US - 1);

  logic [CLK_W-1:0] clk_cnt;
  logic [US_W-1:0]  us_cnt;

  // clocks within the current microsecond
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      clk_cnt <= '0;
    else if (clk_cnt == CLK_LAST)
      clk_cnt <= '0;
    else
      clk_cnt <= clk_cnt + 1'b1;
  end

  // microseconds within the current slot
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (p_1us)
    begin
      if (us_cnt == US_LAST)
        us_cnt <= '0;
      else
        us_cnt <= us_cnt + 1'b1;
    end
  end

  assign p_1us   = (clk_cnt == CLK_LAST);
  assign tslot_p = p_1us & (us_cnt == US_LAST); // slot edge rides on the last us pulse

endmodule

`default_nettype wire

//--- design/ps_ctrl.sv
// Page scan window control. Counts slots across each scan interval and
// opens the scan window at its start, doubled for interlaced scan when the
// interval has room. Also times out a slave page response that stalls.

`timescale 1ns/1ns
`default_nettype none

module ps_ctrl (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        tslot_p,
  input  wire  [lc_pkg::TSCAN_W-1:0] t_ps_interval,
  input  wire  [lc_pkg::TSCAN_W-1:0] t_ps_window,
  input  wire                        ps_interlace,
  input  wire                        page_scan_enable,
  ps_state_if.dst                    st,
  output logic                       page_scan_window,
  output logic                       page_scan_window_endp,
  output logic                       page_scan_window_1more,
  output logic                       page_resp_to
);

  logic [lc_pkg::TSCAN_W-1:0]    win_cnt;
  logic [lc_pkg::TSCAN_W:0]      win_dbl;
  logic                          nor_window;
  logic                          inter_window;
  logic                          use_interlace;
  logic                          window_raw;
  logic [lc_pkg::RESP_CNT_W-1:0] resp_cnt;

  // slot position inside the scan interval
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      win_cnt <= '0;
    else if (!page_scan_enable)
      win_cnt <= '0;
    else if (win_cnt == t_ps_interval)
      win_cnt <= '0;
    else if (page_resp_to)
      win_cnt <= '0; // a failed response starts a fresh interval
    else if (tslot_p)
      win_cnt <= win_cnt + 1'b1;
  end

  assign win_dbl      = {t_ps_window, 1'b0};
  assign nor_window   = (win_cnt < t_ps_window);
  assign inter_window = ({1'b0, win_cnt} < win_dbl);

  // interlace only when two windows fit inside one interval
  assign use_interlace = ps_interlace & ({1'b0, t_ps_interval} >= win_dbl);

  assign window_raw = (use_interlace ? inter_window : nor_window) & page_scan_enable;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      page_scan_window <= 1'b0;
    else
      page_scan_window <= window_raw;
  end

  assign page_scan_window_endp  = !window_raw & page_scan_window;
  assign page_scan_window_1more = nor_window;

  // slots spent waiting for the FHS since the last ID response went out
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      resp_cnt <= '0;
    else if ((st.pstxid & st.corr_endp) | !st.spr)
      resp_cnt <= '0;
    else if (tslot_p)
      resp_cnt <= resp_cnt + 1'b1;
  end

  assign page_resp_to = (resp_cnt == lc_pkg::RESP_TO_SLOTS) & tslot_p;

endmodule

`default_nettype wire

//--- design/ps_substate_fsm.sv
// Page scan substate sequencer. Walks standby, page scan, slave page
// response and connection on the correlator and FHS hits, and issues
// the ID response strobe half a slot after an accepted ID hit.

`timescale 1ns/1ns
`default_nettype none

module ps_substate_fsm #(
  parameter int unsigned SLOT_US = 625
) (
  input  wire               clk_6M,
  input  wire               rstz,
  input  wire               p_1us,
  input  wire               tslot_p,
  input  wire               page_scan_enable,
  input  wire               id_hit,
  input  wire               fhs_hit,
  input  wire               page_scan_window,
  input  wire               page_resp_to,
  ps_state_if.src           st,
  output lc_pkg::ps_state_t state
);

  localparam int unsigned HALF_US = SLOT_US / 2;
  localparam int unsigned DLY_W   = $clog2(HALF_US + 1);

  localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(HALF_US - 1);

  lc_pkg::ps_state_t state_nxt;
  logic              id_accept;
  logic              resp_expired;
  logic [DLY_W-1:0]  dly_cnt;

  assign st.ps  = (state == lc_pkg::ST_PAGE_SCAN);
  assign st.spr = (state == lc_pkg::ST_SLAVE_RESP);

  assign id_accept    = st.ps & id_hit & page_scan_window; // only heard inside the window
  assign resp_expired = page_resp_to & tslot_p;

  always_comb
  begin
    state_nxt = state;
    if (!page_scan_enable)
      state_nxt = lc_pkg::ST_STANDBY;
    else
    begin
      case (state)
        lc_pkg::ST_STANDBY:
          state_nxt = lc_pkg::ST_PAGE_SCAN;
        lc_pkg::ST_PAGE_SCAN:
          if (id_accept)
            state_nxt = lc_pkg::ST_SLAVE_RESP;
        lc_pkg::ST_SLAVE_RESP:
          if (fhs_hit)
            state_nxt = lc_pkg::ST_CONNECTION;
          else if (resp_expired)
            state_nxt = lc_pkg::ST_PAGE_SCAN; // master went quiet so scan again
        default:
          state_nxt = state;
      endcase
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= lc_pkg::ST_STANDBY;
    else
      state <= state_nxt;
  end

  // half slot delay between the ID hit and our ID response
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      st.pstxid    <= 1'b0;
      st.corr_endp <= 1'b0;
      dly_cnt      <= '0;
    end
    else if (!page_scan_enable)
    begin
      st.pstxid    <= 1'b0;
      st.corr_endp <= 1'b0;
      dly_cnt      <= '0;
    end
    else
    begin
      st.corr_endp <= 1'b0;
      if (id_accept)
      begin
        st.pstxid <= 1'b1;
        dly_cnt   <= '0;
      end
      else if (st.corr_endp)
        st.pstxid <= 1'b0; // response sent
      else if (st.pstxid && p_1us)
      begin
        if (dly_cnt == DLY_LAST)
        begin
          st.corr_endp <= 1'b1;
          dly_cnt      <= '0;
        end
        else
          dly_cnt <= dly_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/page_scan_top.sv
// Top level of the page scan block. Ties the slot timer, the substate
// sequencer and the window controller together. Hits come in as plain
// pulses and all outputs are plain levels and strobes.

`timescale 1ns/1ns
`default_nettype none

module page_scan_top #(
  parameter int unsigned SLOT_US    = 625,
  parameter int unsigned CLK_PER_US = 6
) (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        page_scan_enable,
  input  wire  [lc_pkg::TSCAN_W-1:0] t_ps_interval,
  input  wire  [lc_pkg::TSCAN_W-1:0] t_ps_window,
  input  wire                        ps_interlace,
  input  wire                        id_hit,
  input  wire                        fhs_hit,
  output logic                       slot_p,
  output logic                       page_scan_window,
  output logic                       page_scan_window_endp,
  output logic                       page_resp_to,
  output logic                       id_resp_p,
  output lc_pkg::ps_state_t          state
);

  logic p_1us;
  logic tslot_p;

  ps_state_if i_st ();

  slot_timer #(
    .CLK_PER_US (CLK_PER_US),
    .SLOT_US    (SLOT_US)
  ) i_slot_timer (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .p_1us   (p_1us),
    .tslot_p (tslot_p)
  );

  ps_substate_fsm #(
    .SLOT_US (SLOT_US)
  ) i_ps_substate_fsm (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .p_1us            (p_1us),
    .tslot_p          (tslot_p),
    .page_scan_enable (page_scan_enable),
    .id_hit           (id_hit),
    .fhs_hit          (fhs_hit),
    .page_scan_window (page_scan_window),
    .page_resp_to     (page_resp_to),
    .st               (i_st.src),
    .state            (state)
  );

  ps_ctrl i_ps_ctrl (
    .clk_6M                 (clk_6M),
    .rstz                   (rstz),
    .tslot_p                (tslot_p),
    .t_ps_interval          (t_ps_interval),
    .t_ps_window            (t_ps_window),
    .ps_interlace           (ps_interlace),
    .page_scan_enable       (page_scan_enable),
    .st                     (i_st.dst),
    .page_scan_window       (page_scan_window),
    .page_scan_window_endp  (page_scan_window_endp),
    .page_scan_window_1more (),
    .page_resp_to           (page_resp_to)
  );

  assign slot_p    = tslot_p;
  assign id_resp_p = i_st.corr_endp; // ID goes out at the end of the half slot

endmodule

`default_nettype wire

//--- test/tb_page_scan.sv
// Testbench for the page scan block. Drives random scan intervals and windows,
// ID and FHS hits, and checks every output each clock against a cycle model
// built from the slot, window, response and substate timing rules.

`timescale 1ns/1ns
`default_nettype none

module tb_page_scan;

  localparam int unsigned SLOT_US     = 20;
  localparam int unsigned CLK_PER_US  = 6;
  localparam int unsigned SLOT_CLKS   = SLOT_US * CLK_PER_US;
  localparam int unsigned HALF_US     = SLOT_US / 2;
  localparam int unsigned MAX_IV      = 11;
  localparam int unsigned RESP_TO     = 32'(lc_pkg::RESP_TO_SLOTS);
  localparam int unsigned ROUND_SLOTS = 2 * MAX_IV + 4;
  localparam int unsigned WIN_ROUNDS  = 6;
  localparam int unsigned ID_SLOTS    = 4 * (MAX_IV + 2) + RESP_TO + 4;
  localparam int unsigned TOTAL_SLOTS = WIN_ROUNDS * ROUND_SLOTS + ID_SLOTS;
  localparam int unsigned WATCHDOG_NS = (TOTAL_SLOTS * SLOT_CLKS + 500) * 10;

  localparam int W_OPEN   = 0;
  localparam int W_CLOSED = 1;
  localparam int W_IDRESP = 2;
  localparam int W_RESPTO = 3;
  localparam int W_SLOT   = 4;

  logic                       clk_6M;
  logic                       rstz;
  logic                       page_scan_enable;
  logic [lc_pkg::TSCAN_W-1:0] t_ps_interval;
  logic [lc_pkg::TSCAN_W-1:0] t_ps_window;
  logic                       ps_interlace;
  logic                       id_hit;
  logic                       fhs_hit;
  logic                       slot_p;
  logic                       page_scan_window;
  logic                       page_scan_window_endp;
  logic                       page_resp_to;
  logic                       id_resp_p;
  lc_pkg::ps_state_t          state;

  logic [31:0]       seed;
  int unsigned       n_clk;
  int unsigned       m_cnt;
  int unsigned       m_resp;
  int unsigned       m_dly;
  logic              m_pend;
  logic              exp_win;
  logic              exp_idr;
  lc_pkg::ps_state_t m_st;

  page_scan_top #(
    .SLOT_US    (SLOT_US),
    .CLK_PER_US (CLK_PER_US)
  ) i_dut (
    .clk_6M                (clk_6M),
    .rstz                  (rstz),
    .page_scan_enable      (page_scan_enable),
    .t_ps_interval         (t_ps_interval),
    .t_ps_window           (t_ps_window),
    .ps_interlace          (ps_interlace),
    .id_hit                (id_hit),
    .fhs_hit               (fhs_hit),
    .slot_p                (slot_p),
    .page_scan_window      (page_scan_window),
    .page_scan_window_endp (page_scan_window_endp),
    .page_resp_to          (page_resp_to),
    .id_resp_p             (id_resp_p),
    .state                 (state)
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #5 clk_6M = ~clk_6M;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    logic [31:0] r;
    r = next_rand();
    return lo + (32'(r[31:16]) % (hi - lo + 1)); // upper bits have the longer period
  endfunction

  // window is open below the window length or twice that when interlace fits
  function automatic logic ref_window(input int unsigned cnt, input int unsigned iv,
                                      input int unsigned wn, input logic il);
    int unsigned limit;
    limit = wn;
    if (il && (iv >= 2 * wn))
      limit = 2 * wn;
    return (cnt < limit);
  endfunction

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp)
    begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out after waiting too long for %s", what);
    $display("TB FAILED");
    $fatal(1, "wait timeout");
  endtask

  // outputs are read on the falling edge where they are stable
  task automatic wait_for(input int sel, input int unsigned max_clk, input string what);
    int unsigned k;
    logic        hit;
    k   = 0;
    hit = 1'b0;
    while (!hit)
    begin
      @(negedge clk_6M);
      case (sel)
        W_OPEN:   hit = page_scan_window;
        W_CLOSED: hit = !page_scan_window;
        W_IDRESP: hit = id_resp_p;
        W_RESPTO: hit = page_resp_to;
        default:  hit = slot_p;
      endcase
      k++;
      if (!hit && (k >= max_clk))
        fail_timeout(what);
    end
  endtask

  task automatic wait_slots(input int unsigned n);
    repeat (n) wait_for(W_SLOT, SLOT_CLKS + 1, "slot pulse");
  endtask

  task automatic pulse_id();
    id_hit = 1'b1;
    @(negedge clk_6M);
    id_hit = 1'b0;
  endtask

  task automatic pulse_fhs();
    fhs_hit = 1'b1;
    @(negedge clk_6M);
    fhs_hit = 1'b0;
  endtask

  // parameters only change while scanning is off so the slot count restarts
  task automatic set_scan(input int unsigned iv, input int unsigned wn, input logic il);
    @(negedge clk_6M);
    page_scan_enable = 1'b0;
    t_ps_interval    = 16'(iv);
    t_ps_window      = 16'(wn);
    ps_interlace     = il;
    repeat (2) @(negedge clk_6M);
    page_scan_enable = 1'b1;
  endtask

  task automatic window_round(input logic il, input logic wide);
    int unsigned iv;
    int unsigned wn;
    iv = rand_range(4, MAX_IV);
    if (wide)
      wn = rand_range(iv / 2 + 1, iv - 1); // too long to double
    else
      wn = rand_range(1, iv / 2);
    set_scan(iv, wn, il);
    wait_slots(2 * iv + 3);
  endtask

  task automatic hit_in_window(input logic probe_closed);
    wait_for(W_CLOSED, (MAX_IV + 2) * SLOT_CLKS, "window to close");
    if (probe_closed)
      pulse_id(); // must be ignored
    wait_for(W_OPEN, (MAX_IV + 2) * SLOT_CLKS, "window to open");
    repeat (rand_range(0, 15)) @(negedge clk_6M);
    pulse_id();
  endtask

  task automatic id_section();
    set_scan(rand_range(6, MAX_IV), rand_range(1, 2), rand_range(0, 1) == 1);
    @(negedge clk_6M);
    pulse_fhs(); // no effect outside slave response
    hit_in_window(1'b1);
    wait_for(W_IDRESP, (HALF_US + 2) * CLK_PER_US, "ID response");
    wait_for(W_RESPTO, (RESP_TO + 2) * SLOT_CLKS, "page response timeout");
    hit_in_window(1'b0);
    wait_for(W_IDRESP, (HALF_US + 2) * CLK_PER_US, "ID response");
    repeat (rand_range(1, 20)) @(negedge clk_6M);
    pulse_fhs();
    repeat (10) @(negedge clk_6M);
    page_scan_enable = 1'b0;
    repeat (10) @(negedge clk_6M);
  endtask

  // cycle model sampled before the DUT flops update
  always @(posedge clk_6M)
  begin : compare
    logic p1;
    logic sl;
    logic raw;
    logic acc;
    logic exp_endp;
    logic exp_to;
    if (!rstz)
    begin
      n_clk   = 0;
      m_cnt   = 0;
      m_resp  = 0;
      m_dly   = 0;
      m_pend  = 1'b0;
      exp_win = 1'b0;
      exp_idr = 1'b0;
      m_st    = lc_pkg::ST_STANDBY;
    end
    else
    begin
      p1       = ((n_clk % CLK_PER_US) == CLK_PER_US - 1);
      sl       = p1 && (((n_clk / CLK_PER_US) % SLOT_US) == SLOT_US - 1);
      raw      = ref_window(m_cnt, 32'(t_ps_interval), 32'(t_ps_window), ps_interlace)
                 & page_scan_enable;
      exp_endp = exp_win & !raw;
      exp_to   = sl && (m_resp == RESP_TO);
      acc      = (m_st == lc_pkg::ST_PAGE_SCAN) && id_hit && exp_win;

      check_val("slot_p", 32'(slot_p), 32'(sl));
      check_val("page_scan_window", 32'(page_scan_window), 32'(exp_win));
      check_val("page_scan_window_endp", 32'(page_scan_window_endp), 32'(exp_endp));
      check_val("page_resp_to", 32'(page_resp_to), 32'(exp_to));
      check_val("id_resp_p", 32'(id_resp_p), 32'(exp_idr));
      check_val("state", 32'(state), 32'(m_st));

      if (exp_idr || (m_st != lc_pkg::ST_SLAVE_RESP))
        m_resp = 0;
      else if (sl)
        m_resp = m_resp + 1;

      if (!page_scan_enable || (m_cnt == 32'(t_ps_interval)) || exp_to)
        m_cnt = 0;
      else if (sl)
        m_cnt = m_cnt + 1;

      if (!page_scan_enable)
      begin
        m_pend  = 1'b0;
        m_dly   = 0;
        exp_idr = 1'b0;
      end
      else if (acc)
      begin
        m_pend  = 1'b1;
        m_dly   = 0;
        exp_idr = 1'b0;
      end
      else if (exp_idr)
      begin
        m_pend  = 1'b0;
        exp_idr = 1'b0;
      end
      else if (m_pend && p1)
      begin
        if (m_dly == HALF_US - 1)
        begin
          exp_idr = 1'b1;
          m_dly   = 0;
        end
        else
          m_dly = m_dly + 1;
      end

      if (!page_scan_enable)
        m_st = lc_pkg::ST_STANDBY;
      else
      begin
        case (m_st)
          lc_pkg::ST_STANDBY:
            m_st = lc_pkg::ST_PAGE_SCAN;
          lc_pkg::ST_PAGE_SCAN:
            if (acc)
              m_st = lc_pkg::ST_SLAVE_RESP;
          lc_pkg::ST_SLAVE_RESP:
            if (fhs_hit)
              m_st = lc_pkg::ST_CONNECTION;
            else if (exp_to)
              m_st = lc_pkg::ST_PAGE_SCAN;
          default:
            m_st = m_st;
        endcase
      end

      exp_win = raw;
      n_clk   = n_clk + 1;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired because the tests did not finish in the expected time");
    $display("TB FAILED");
    $fatal(1, "watchdog");
  end

  initial
  begin
    seed             = 32'h287b;
    rstz             = 1'b0;
    page_scan_enable = 1'b0;
    t_ps_interval    = '0;
    t_ps_window      = '0;
    ps_interlace     = 1'b0;
    id_hit           = 1'b0;
    fhs_hit          = 1'b0;
    repeat (8) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
    repeat (5) @(negedge clk_6M); // standby while scanning is off

    repeat (3) window_round(1'b0, rand_range(0, 1) == 1);
    repeat (2) window_round(1'b1, 1'b0);
    window_round(1'b1, 1'b1); // interlace falls back to the normal window
    id_section();

    check_val("final state", 32'(state), 32'(lc_pkg::ST_STANDBY));
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
design/lc_pkg.sv
design/ps_state_if.sv
design/slot_timer.sv
design/ps_ctrl.sv
design/ps_substate_fsm.sv
design/page_scan_top.sv
test/tb_page_scan.sv

//--- Makefile
# Verilator build for the page scan block

TOOL       = verilator
TOP        = tb_page_scan
FILELIST   = compile.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run status is ignored, the log decides pass or fail
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
